//--- test/sysio_stim.txt
# write addr data | read addr exp|m | pair addr exp|m addr exp|m (hex, m = model)
# wait cycles | pause level | menu level | flag pause|menu level | ctl value (hex)
flag menu 0
ctl 00
read 8002 m
read 8006 m
read 8007 m
read 8029 m
read 803a m
read 8051 m
read 8052 m
read 80f9 m
read 80fa 00
read 81ba m
read 81c0 m
read 81e9 m
read 824a m
read 824b m
read 8255 m
read 81ea 00
read 7fff 00
write 802b 77
read 802a 00
read 802b 00
wait 48000
read 802a 02
write 8001 5a
ctl 5a
read 8001 5a
write 82b6 01
flag pause 1
pause 1
wait 2
flag pause 1
pause 0
flag pause 0
menu 1
read 8000 0a
flag menu 1
menu 0
read 8000 08
read 82b7 ff
write 82b7 00
flag menu 0
read 82b7 00
pair 8002 m 803a m
pair 8001 5a 824b m

//--- all.f
source/sysio_pkg.sv
source/io_bus_if.sv
source/input_map.sv
source/system_regs.sv
source/read_return.sv
source/sysio_top.sv
test/tb_sysio.sv

//--- test/tb_sysio.sv
`timescale 1ns/1ns
`default_nettype none

module tb_sysio
	import sysio_pkg::*;
();

	logic clk_24;
	logic rst;
	addr_t addr;
	byte_t wdata;
	logic wr;
	logic rd;
	byte_t rdata;
	logic rvalid;
	logic pause;
	logic menu;
	logic [JOYSTICK_WIDTH-1:0] joystick;
	logic [PADDLE_WIDTH-1:0] paddle;
	logic [PS2_KEY_WIDTH-1:0] ps2_key;
	logic [TIMESTAMP_WIDTH-1:0] timestamp;
	logic pause_system;
	logic menu_pending;
	byte_t video_control;
	int cycles = 0;
	int cycle_limit = 0;

	sysio_top u_dut (.*);

	initial
	begin
		clk_24 = 1'b0;
		forever #5 clk_24 = ~clk_24;
	end

	task automatic stop_run(input string what);
		$display("%s", what);
		$display("TEST FAIL");
		$fatal(1, "run stopped at first error");
	endtask

	task automatic check_byte(input string what, input byte_t got, input byte_t exp);
		if (got !== exp)
			stop_run($sformatf("mismatch at %0t: %s read %h, expected %h", $time, what, got, exp));
	endtask

	task automatic check_flag(input string what, input logic got, input logic exp);
		if (got !== exp)
			stop_run($sformatf("mismatch at %0t: %s is %b, expected %b", $time, what, got, exp));
	endtask

	task automatic check_ctl(input byte_t got, input byte_t exp);
		if (got !== exp)
			stop_run($sformatf("mismatch at %0t: video_control is %h, expected %h",
				$time, got, exp));
	endtask

	// Runs out of cycles only if the DUT or the command flow stalls
	always @(posedge clk_24)
	begin
		cycles <= cycles + 1;
		if (cycle_limit > 0 && cycles >= cycle_limit)
			stop_run($sformatf("timeout after %0d cycles, command file not finished", cycles));
	end

	// Byte k of a region vector with zeros above its width, k wraps on the byte count
	function automatic byte_t model_byte(input addr_t a);
		logic [JOYSTICK_WIDTH-1:0] v;
		int k;
		v = '0;
		k = 0;
		if (a >= 16'h8002 && a < 16'h802A)
		begin
			v = JOYSTICK_WIDTH'(timestamp);
			k = (a - 16'h8002) % 5;
		end
		else if (a >= 16'h803A && a < 16'h80FA)
		begin
			v = joystick;
			k = (a - 16'h803A) % 24;
		end
		else if (a >= 16'h81BA && a < 16'h81EA)
		begin
			v = JOYSTICK_WIDTH'(paddle);
			k = (a - 16'h81BA) % 6;
		end
		else if (a >= 16'h824A && a < 16'h8256)
		begin
			v = JOYSTICK_WIDTH'(ps2_key);
			k = (a - 16'h824A) % 2;
		end
		return byte_t'(v >> (8 * k));
	endfunction

	function automatic byte_t expect_of(input addr_t a, input string tok);
		byte_t e;
		e = '0;
		if (tok == "m")
			e = model_byte(a);
		else
			void'($sscanf(tok, "%h", e));
		return e;
	endfunction

	// Read data is due at the first falling edge after the edge that sampled rd
	task automatic check_valid(input addr_t a);
		if (rvalid !== 1'b1)
			stop_run($sformatf("read of address %h got no response in the next cycle", a));
	endtask

	task automatic do_write(input addr_t a, input byte_t d);
		@(negedge clk_24);
		addr = a;
		wdata = d;
		wr = 1'b1;
		@(negedge clk_24);
		wr = 1'b0;
	endtask

	task automatic do_read(input addr_t a, input byte_t e);
		@(negedge clk_24);
		check_flag("rvalid before a read", rvalid, 1'b0);
		addr = a;
		rd = 1'b1;
		@(negedge clk_24);
		rd = 1'b0;
		check_valid(a);
		check_byte($sformatf("address %h", a), rdata, e);
	endtask

	// Second read is issued while the first result is returned
	task automatic do_pair(input addr_t a1, input byte_t e1, input addr_t a2, input byte_t e2);
		@(negedge clk_24);
		check_flag("rvalid before a read", rvalid, 1'b0);
		addr = a1;
		rd = 1'b1;
		@(negedge clk_24);
		addr = a2;
		check_valid(a1);
		check_byte($sformatf("address %h", a1), rdata, e1);
		@(negedge clk_24);
		rd = 1'b0;
		check_valid(a2);
		check_byte($sformatf("address %h", a2), rdata, e2);
	endtask

	initial
	begin
		string line;
		string cmd;
		string t1;
		string t2;
		int fd;
		int n;
		int count;
		int waits;
		int cmds;
		addr_t a1;
		addr_t a2;
		byte_t d;
		rst = 1'b1;
		addr = '0;
		wdata = '0;
		wr = 1'b0;
		// Read strobe is held high through reset, so only the reset keeps rvalid low
		rd = 1'b1;
		pause = 1'b0;
		menu = 1'b0;
		void'($urandom(32'h2cc9));
		for (int i = 0; i < 6; i++)
			joystick[i*32 +: 32] = $urandom();
		paddle = {16'($urandom()), 32'($urandom())};
		ps2_key = 11'($urandom());
		timestamp = {1'($urandom()), 32'($urandom())};

		// First pass sizes the cycle limit
		fd = $fopen("test/sysio_stim.txt", "r");
		if (fd == 0)
			stop_run("could not open the stimulus file test/sysio_stim.txt");
		waits = 0;
		cmds = 0;
		while ($fgets(line, fd) != 0)
		begin
			n = $sscanf(line, "%s %d", cmd, count);
			if (n >= 1 && cmd[0] != "#")
			begin
				cmds++;
				if (cmd == "wait")
					waits += count;
			end
		end
		$fclose(fd);
		cycle_limit = waits + 4 * cmds + 100;

		repeat (3) @(negedge clk_24);
		rst = 1'b0;
		rd = 1'b0;
		check_flag("rvalid after reset", rvalid, 1'b0);

		fd = $fopen("test/sysio_stim.txt", "r");
		while ($fgets(line, fd) != 0)
		begin
			n = $sscanf(line, "%s", cmd);
			if (n < 1 || cmd[0] == "#")
				continue;
			if (cmd == "write")
			begin
				void'($sscanf(line, "%s %h %h", cmd, a1, d));
				do_write(a1, d);
			end
			else if (cmd == "read")
			begin
				void'($sscanf(line, "%s %h %s", cmd, a1, t1));
				do_read(a1, expect_of(a1, t1));
			end
			else if (cmd == "pair")
			begin
				void'($sscanf(line, "%s %h %s %h %s", cmd, a1, t1, a2, t2));
				do_pair(a1, expect_of(a1, t1), a2, expect_of(a2, t2));
			end
			else if (cmd == "wait")
			begin
				void'($sscanf(line, "%s %d", cmd, count));
				repeat (count) @(negedge clk_24);
			end
			else if (cmd == "pause" || cmd == "menu")
			begin
				void'($sscanf(line, "%s %d", cmd, count));
				@(negedge clk_24);
				if (cmd == "pause")
					pause = count[0];
				else
					menu = count[0];
			end
			else if (cmd == "flag")
			begin
				void'($sscanf(line, "%s %s %d", cmd, t1, count));
				@(negedge clk_24);
				if (t1 == "pause")
					check_flag("pause_system", pause_system, count[0]);
				else
					check_flag("menu_pending", menu_pending, count[0]);
			end
			else if (cmd == "ctl")
			begin
				void'($sscanf(line, "%s %h", cmd, d));
				@(negedge clk_24);
				check_ctl(video_control, d);
			end
			else
				stop_run({"unknown command in the stimulus file: ", cmd});
		end
		$fclose(fd);
		$display("TEST PASS");
		$finish;
	end

endmodule

`default_nettype wire

//--- source/sysio_top.sv
`timescale 1ns/1ns
`default_nettype none

module sysio_top
	import sysio_pkg::*;
(
	input wire logic clk_24,
	input wire logic rst,

	// CPU side bus
	input wire addr_t addr,
	input wire byte_t wdata,
	input wire logic wr,
	input wire logic rd,
	output byte_t rdata,
	output logic rvalid,

	// Host control
	input wire logic pause,
	input wire logic menu,

	// Hardware inputs
	input wire logic [JOYSTICK_WIDTH-1:0] joystick,
	input wire logic [PADDLE_WIDTH-1:0] paddle,
	input wire logic [PS2_KEY_WIDTH-1:0] ps2_key,
	input wire logic [TIMESTAMP_WIDTH-1:0] timestamp,

	output logic pause_system,
	output logic menu_pending,
	output byte_t video_control
);

	logic in_hit;
	byte_t in_data;
	logic sys_hit;
	byte_t sys_data;

	io_bus_if bus ();

	// Host side of the bus
	assign bus.addr = addr;
	assign bus.wdata = wdata;
	assign bus.wr = wr;
	assign bus.rd = rd;

	input_map u_input_map (
		.clk_24 (clk_24),
		.rst (rst),
		.bus (bus),
		.joystick (joystick),
		.paddle (paddle),
		.ps2_key (ps2_key),
		.timestamp (timestamp),
		.in_hit (in_hit),
		.in_data (in_data)
	);

	system_regs u_system_regs (
		.clk_24 (clk_24),
		.rst (rst),
		.bus (bus),
		.pause (pause),
		.menu (menu),
		.sys_hit (sys_hit),
		.sys_data (sys_data),
		.pause_system (pause_system),
		.menu_pending (menu_pending),
		.video_control (video_control)
	);

	read_return u_read_return (
		.clk_24 (clk_24),
		.rst (rst),
		.rd (rd),
		.in_hit (in_hit),
		.in_data (in_data),
		.sys_hit (sys_hit),
		.sys_data (sys_data),
		.rdata (rdata),
		.rvalid (rvalid)
	);

endmodule

`default_nettype wire

//--- source/read_return.sv
`timescale 1ns/1ns
`default_nettype none

module read_return
	import sysio_pkg::*;
(
	input wire logic clk_24,
	input wire logic rst,
	input wire logic rd,
	input wire logic in_hit,
	input wire byte_t in_data,
	input wire logic sys_hit,
	input wire byte_t sys_data,
	output byte_t rdata,
	output logic rvalid
);

	byte_t sel_data;

	// Unmapped addresses read as zero
	always_comb
	begin
		if (in_hit)
			sel_data = in_data;
		else if (sys_hit)
			sel_data = sys_data;
		else
			sel_data = '0;
	end

	// Read data is captured only on a read, so a result holds until the next one
	always_ff @(posedge clk_24)
	begin
		if (rd)
			rdata <= sel_data;
	end

	always_ff @(posedge clk_24)
	begin
		if (rst)
			rvalid <= 1'b0;
		else
			rvalid <= rd;
	end

	// Input and system regions never overlap in the memory map
	a_one_hit: assert property (@(posedge clk_24) disable iff (rst) !(in_hit && sys_hit));

endmodule

`default_nettype wire

//--- source/system_regs.sv
`timescale 1ns/1ns
`default_nettype none

module system_regs
	import sysio_pkg::*;
(
	input wire logic clk_24,
	input wire logic rst,
	io_bus_if.device bus,
	input wire logic pause,
	input wire logic menu,
	output logic sys_hit,
	output byte_t sys_data,
	output logic pause_system,
	output logic menu_pending,
	output byte_t video_control
);

	logic in0_cs;
	logic video_ctl_cs;
	logic timer_cs;
	logic pause_cs;
	logic menu_cs;
	logic timer_clear;
	logic ms_tick;
	addr_t timer_off;
	logic [PRESCALE_WIDTH-1:0] prescaler;
	logic [TIMER_WIDTH-1:0] timer;
	logic pause_trigger;
	byte_t in0_data;

	// Address decode
	assign in0_cs = bus.addr == MAP_IN0;
	assign video_ctl_cs = bus.addr == MAP_VIDEO_CTL;
	assign timer_cs = (bus.addr >= MAP_TIMER_START) && (bus.addr < MAP_JOYSTICK_START);
	assign pause_cs = bus.addr == MAP_SYSTEM_PAUSE;
	assign menu_cs = bus.addr == MAP_SYSTEM_MENU;

	// Any write into the timer region restarts the count, data is ignored
	assign timer_clear = bus.wr && timer_cs;
	assign ms_tick = prescaler == PRESCALE_WIDTH'(TICKS_PER_MS - 1);
	assign timer_off = bus.addr - MAP_TIMER_START;

	always_ff @(posedge clk_24)
	begin
		if (rst || timer_clear)
		begin
			prescaler <= '0;
			timer <= '0;
		end
		else if (ms_tick)
		begin
			prescaler <= '0;
			timer <= timer + 1'b1;
		end
		else
		begin
			prescaler <= prescaler + 1'b1;
		end
	end

	// Video control byte
	always_ff @(posedge clk_24)
	begin
		if (rst)
			video_control <= '0;
		else if (bus.wr && video_ctl_cs)
			video_control <= bus.wdata;
	end

	// Pause trigger, the pause input clears it ahead of a write
	always_ff @(posedge clk_24)
	begin
		if (rst || pause)
			pause_trigger <= 1'b0;
		else if (bus.wr && pause_cs)
			pause_trigger <= 1'b1;
	end

	assign pause_system = pause || pause_trigger;

	// Menu trigger, an acknowledging write wins over the menu input
	always_ff @(posedge clk_24)
	begin
		if (rst)
			menu_pending <= 1'b0;
		else if (bus.wr && menu_cs)
			menu_pending <= 1'b0;
		else if (menu)
			menu_pending <= 1'b1;
	end

	// Status byte with live menu level in bit 1
	assign in0_data = {4'b0000, IN0_FIXED, menu, 1'b0};

	assign sys_hit = in0_cs || video_ctl_cs || timer_cs || menu_cs;

	always_comb
	begin
		sys_data = '0;
		if (in0_cs)
			sys_data = in0_data;
		else if (video_ctl_cs)
			sys_data = video_control;
		else if (timer_cs)
			// Little endian, odd offsets give the high byte
			sys_data = timer[{timer_off[0], 3'd0} +: 8];
		else if (menu_cs)
			sys_data = {8{menu_pending}};
	end

	a_prescale_range: assert property (@(posedge clk_24) disable iff (rst)
		prescaler <= PRESCALE_WIDTH'(TICKS_PER_MS - 1));

endmodule

`default_nettype wire

//--- source/input_map.sv
`timescale 1ns/1ns
`default_nettype none

module input_map
	import sysio_pkg::*;
(
	input wire logic clk_24,
	input wire logic rst,
	io_bus_if.device bus,
	input wire logic [JOYSTICK_WIDTH-1:0] joystick,
	input wire logic [PADDLE_WIDTH-1:0] paddle,
	input wire logic [PS2_KEY_WIDTH-1:0] ps2_key,
	input wire logic [TIMESTAMP_WIDTH-1:0] timestamp,
	output logic in_hit,
	output byte_t in_data
);

	// Byte k of a zero padded vector, k is the offset wrapped on the byte count
	function automatic byte_t pick_byte(
		input logic [JOYSTICK_WIDTH-1:0] vec,
		input addr_t offset,
		input addr_t count
	);
		addr_t k;
		k = offset % count;
		return vec[k*8 +: 8];
	endfunction

	logic ts_cs;
	logic joy_cs;
	logic pad_cs;
	logic key_cs;
	addr_t ts_off;
	addr_t joy_off;
	addr_t pad_off;
	addr_t key_off;

	// Region decode
	assign ts_cs = (bus.addr >= MAP_TIMESTAMP_START) && (bus.addr < MAP_TIMER_START);
	assign joy_cs = (bus.addr >= MAP_JOYSTICK_START) && (bus.addr < MAP_JOYSTICK_END);
	assign pad_cs = (bus.addr >= MAP_PADDLE_START) && (bus.addr < MAP_SPINNER_START);
	assign key_cs = (bus.addr >= MAP_PS2_KEY_START) && (bus.addr < MAP_PS2_MOUSE_START);

	assign ts_off = bus.addr - MAP_TIMESTAMP_START;
	assign joy_off = bus.addr - MAP_JOYSTICK_START;
	assign pad_off = bus.addr - MAP_PADDLE_START;
	assign key_off = bus.addr - MAP_PS2_KEY_START;

	assign in_hit = ts_cs || joy_cs || pad_cs || key_cs;

	always_comb
	begin
		in_data = '0;
		if (ts_cs)
			in_data = pick_byte(JOYSTICK_WIDTH'(timestamp), ts_off, addr_t'(TIMESTAMP_BYTES));
		else if (joy_cs)
			in_data = pick_byte(joystick, joy_off, addr_t'(JOYSTICK_BYTES));
		else if (pad_cs)
			in_data = pick_byte(JOYSTICK_WIDTH'(paddle), pad_off, addr_t'(PADDLE_BYTES));
		else if (key_cs)
			in_data = pick_byte(JOYSTICK_WIDTH'(ps2_key), key_off, addr_t'(PS2_KEY_BYTES));
	end

	// The host never issues a read and a write in the same cycle
	a_no_rd_wr: assert property (@(posedge clk_24) disable iff (rst) !(bus.rd && bus.wr));

endmodule

`default_nettype wire

//--- source/io_bus_if.sv
`timescale 1ns/1ns
`default_nettype none

interface io_bus_if
	import sysio_pkg::*;
();

	addr_t addr;
	byte_t wdata;
	logic wr;
	logic rd;

	// Bus master side
	modport host (
		output addr, wdata, wr, rd
	);

	// Decoding parts only look at the bus
	modport device (
		input addr, wdata, wr, rd
	);

endinterface

`default_nettype wire

//--- source/sysio_pkg.sv
`default_nettype none

package sysio_pkg;

	// Bus word types
	typedef logic [7:0] byte_t;
	typedef logic [15:0] addr_t;

	// System register addresses
	localparam addr_t MAP_IN0 = 16'h8000;
	localparam addr_t MAP_VIDEO_CTL = 16'h8001;
	localparam addr_t MAP_SYSTEM_PAUSE = 16'h82B6;
	localparam addr_t MAP_SYSTEM_MENU = 16'h82B7;

	// Region starts, each region ends where the next one starts
	localparam addr_t MAP_TIMESTAMP_START = 16'h8002;
	localparam addr_t MAP_TIMER_START = 16'h802A;
	localparam addr_t MAP_JOYSTICK_START = 16'h803A;
	localparam addr_t MAP_JOYSTICK_END = 16'h80FA;
	localparam addr_t MAP_PADDLE_START = 16'h81BA;
	localparam addr_t MAP_SPINNER_START = 16'h81EA;
	localparam addr_t MAP_PS2_KEY_START = 16'h824A;
	localparam addr_t MAP_PS2_MOUSE_START = 16'h8256;

	// Input vector widths
	localparam int JOYSTICK_WIDTH = 192;
	localparam int PADDLE_WIDTH = 48;
	localparam int PS2_KEY_WIDTH = 11;
	localparam int TIMESTAMP_WIDTH = 33;

	// Bytes per input vector, offsets wrap on these
	localparam int TIMESTAMP_BYTES = 5;
	localparam int JOYSTICK_BYTES = 24;
	localparam int PADDLE_BYTES = 6;
	localparam int PS2_KEY_BYTES = 2;

	// Millisecond timer
	localparam int TIMER_WIDTH = 16;
	localparam int TICKS_PER_MS = 24000;
	localparam int PRESCALE_WIDTH = 15;

	// Status byte fixed field, bits 3..2
	localparam logic [1:0] IN0_FIXED = 2'b10;

endpackage

`default_nettype wire
